// ==== logic/clk_src_defs.svh ====
`ifndef CLK_SRC_DEFS_SVH
`define CLK_SRC_DEFS_SVH

//----------------------------------------------------------------------------
// Comparator clock phase stepping
//----------------------------------------------------------------------------
`define CMP_TABLE_DEPTH      32     // Coarse phase settings
`define CMP_REQ_W            5
`define CMP_PHASE_W          11
// 25 ns times 56 steps per VCO period times a 960 MHz VCO
`define CMP_STEPS_PER_CYCLE  1344

//----------------------------------------------------------------------------
// Sampling clock resync
//----------------------------------------------------------------------------
`define MMCM_RST_PIPE_LEN    8      // Reset stretch for the sampling MMCM
`define CLK40_PER_US         40
`define DSR_HOLDOFF_US       100
`define SAMP_PHASE_W         3

`endif

// ==== logic/samp_clk_pkg.sv ====
`default_nettype none

`include "clk_src_defs.svh"

package samp_clk_pkg;

	typedef logic [`SAMP_PHASE_W-1:0] samp_phase_t;       // ADC clock phase select
	typedef logic [`MMCM_RST_PIPE_LEN-1:0] rst_pipe_t;
	typedef logic [7:0] holdoff_cnt_t;                    // Counts 1 us ticks

	// Control outputs toward the sampling clock tree
	typedef struct packed {
		logic lead_edg_resync;
		logic cap_phase;
		logic rst_samp_mmcm;
		logic samp_in_sel;    // Picks clk20 or its inverse
	} samp_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/cmp_phase_pkg.sv ====
`default_nettype none

`include "clk_src_defs.svh"

package cmp_phase_pkg;

	typedef logic [`CMP_REQ_W-1:0] cmp_req_t;        // Coarse request from the host
	typedef logic [`CMP_PHASE_W-1:0] cmp_phase_t;    // Fine phase in MMCM steps

	// Dynamic phase shift sequencer
	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		SHIFT     = 3'd1,
		WAIT_DONE = 3'd2,
		SETTLE1   = 3'd3,
		SETTLE2   = 3'd4
	} dps_state_t;

	typedef struct packed {
		logic psen;            // To MMCM PSEN
		logic busy;
		dps_state_t state;
	} cmp_phs_stat_t;

endpackage

`default_nettype wire

// ==== logic/resync_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clk_src_defs.svh"

module resync_ctrl (
	input  wire                        CLK40,
	input  wire                        RST,
	input  wire                        resync,
	input  wire                        samp_clk_phs_chng,
	input  wire samp_clk_pkg::samp_phase_t samp_clk_phase,
	output samp_clk_pkg::samp_ctrl_t   samp_ctrl
);

	logic [1:0] rst_dly;                      // Both bits set while in reset
	logic resync_d1;
	logic lead_edg_resync;
	logic lead_edg_resync_d1;
	logic trl_edg_rst;
	logic cap_phase;
	logic pipe_in;
	samp_clk_pkg::rst_pipe_t rst_mmcm_pipe;
	logic clk20_phase;                        // Free running 20 MHz parity
	logic c20_phase_sel;

	//--------------------------------------------------------------------------
	// Trigger detection
	//--------------------------------------------------------------------------
	assign lead_edg_resync = resync & ~resync_d1;    // One clock wide
	assign trl_edg_rst = ~RST & rst_dly[1];          // Two clocks wide

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			rst_dly <= 2'b11;
			resync_d1 <= 1'b0;
			lead_edg_resync_d1 <= 1'b0;
			cap_phase <= 1'b0;
		end else begin
			rst_dly <= {rst_dly[0], 1'b0};
			resync_d1 <= resync;
			lead_edg_resync_d1 <= lead_edg_resync;
			cap_phase <= lead_edg_resync | lead_edg_resync_d1 | trl_edg_rst | samp_clk_phs_chng;
		end
	end

	//--------------------------------------------------------------------------
	// Sampling MMCM reset stretch
	//--------------------------------------------------------------------------
	assign pipe_in = lead_edg_resync | trl_edg_rst | cap_phase | samp_clk_phs_chng;

	// MMCM held in reset for the whole of RST
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			rst_mmcm_pipe <= '1;
		else
			rst_mmcm_pipe <= {rst_mmcm_pipe[`MMCM_RST_PIPE_LEN-2:0], pipe_in};
	end

	//--------------------------------------------------------------------------
	// 20 MHz half cycle phase
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			clk20_phase <= 1'b0;
			c20_phase_sel <= 1'b0;
		end else begin
			clk20_phase <= lead_edg_resync ? 1'b0 : ~clk20_phase;   // Aligned to resync
			if (cap_phase)
				c20_phase_sel <= clk20_phase;
		end
	end

	assign samp_ctrl = '{
		lead_edg_resync: lead_edg_resync,
		cap_phase:       cap_phase,
		rst_samp_mmcm:   |rst_mmcm_pipe,
		samp_in_sel:     samp_clk_phase[`SAMP_PHASE_W-1] ^ c20_phase_sel
	};

endmodule

`default_nettype wire

// ==== logic/dsr_holdoff.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clk_src_defs.svh"

module dsr_holdoff (
	input  wire  CLK40,
	input  wire  RST,
	input  wire  cap_phase,
	output logic dsr_resync
);

	localparam int DIV_W = $clog2(`CLK40_PER_US);

	logic [DIV_W-1:0] div_cnt;
	logic us_tick;
	samp_clk_pkg::holdoff_cnt_t ho_cnt;
	logic clr_dsr_ho;

	//--------------------------------------------------------------------------
	// 1 us enable from CLK40
	//--------------------------------------------------------------------------
	assign us_tick = (div_cnt == DIV_W'(`CLK40_PER_US - 1));

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			div_cnt <= '0;
		else if (us_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	//--------------------------------------------------------------------------
	// Data stream resync holdoff
	//--------------------------------------------------------------------------
	assign clr_dsr_ho = (ho_cnt == samp_clk_pkg::holdoff_cnt_t'(`DSR_HOLDOFF_US));   // 100 us

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			dsr_resync <= 1'b0;
			ho_cnt <= '0;
		end else begin
			if (cap_phase)
				dsr_resync <= 1'b1;
			else if (clr_dsr_ho)
				dsr_resync <= 1'b0;

			// Each capture starts a full holdoff
			if (cap_phase)
				ho_cnt <= '0;
			else if (us_tick)
				ho_cnt <= dsr_resync ? ho_cnt + 1'b1 : '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cmp_phase_track.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clk_src_defs.svh"

module cmp_phase_track (
	input  wire                         CLK40,
	input  wire                         cmp_phs_rst,
	input  wire cmp_phase_pkg::cmp_req_t cmp_clk_phase,
	input  wire                         psen,
	output cmp_phase_pkg::cmp_phase_t   cmp_phase,
	output logic                        cmp_phs_inc,
	output logic                        cmp_phs_change
);

	//--------------------------------------------------------------------------
	// Coarse to fine lookup
	// Entry i is round(i * 1344 / 31) so 31 lands on a full 25 ns cycle
	//--------------------------------------------------------------------------
	cmp_phase_pkg::cmp_phase_t cmp_rom [0:`CMP_TABLE_DEPTH-1];
	cmp_phase_pkg::cmp_phase_t cur_cmp_phase;    // Presumed phase inside the MMCM
	logic cmp_phs_chg_m1;

	initial begin
		$readmemh("comp_phase.hex", cmp_rom);
	end

	always_ff @(posedge CLK40) begin
		cmp_phase <= cmp_rom[cmp_clk_phase];
	end

	//--------------------------------------------------------------------------
	// Direction and change flags
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge cmp_phs_rst) begin
		if (cmp_phs_rst) begin
			cmp_phs_inc <= 1'b0;
			cmp_phs_chg_m1 <= 1'b0;
			cmp_phs_change <= 1'b0;
		end else begin
			cmp_phs_inc <= (cmp_phase > cur_cmp_phase);
			cmp_phs_chg_m1 <= (cmp_phase != cur_cmp_phase);
			cmp_phs_change <= cmp_phs_chg_m1;      // Extra stage lets the step settle
		end
	end

	// Must match the MMCM's preset phase after its reset
	always_ff @(posedge CLK40 or posedge cmp_phs_rst) begin
		if (cmp_phs_rst)
			cur_cmp_phase <= '0;
		else if (psen) begin
			if (cmp_phs_inc)
				cur_cmp_phase <= cur_cmp_phase + 1'b1;
			else
				cur_cmp_phase <= cur_cmp_phase - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dyn_phase_shift_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module dyn_phase_shift_fsm (
	input  wire                           CLK40,
	input  wire                           cmp_phs_rst,
	input  wire                           mmcm_locked,
	input  wire                           cmp_phs_change,
	input  wire                           mmcm_ps_done,
	output cmp_phase_pkg::cmp_phs_stat_t  cmp_phs_stat
);

	cmp_phase_pkg::dps_state_t state;
	cmp_phase_pkg::dps_state_t next_state;

	//--------------------------------------------------------------------------
	// One fine step per pass
	//--------------------------------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			cmp_phase_pkg::IDLE: begin
				if (mmcm_locked && cmp_phs_change)
					next_state = cmp_phase_pkg::SHIFT;
			end
			cmp_phase_pkg::SHIFT: begin
				next_state = cmp_phase_pkg::WAIT_DONE;     // PSEN lasts one clock
			end
			cmp_phase_pkg::WAIT_DONE: begin
				if (mmcm_ps_done)
					next_state = cmp_phase_pkg::SETTLE1;
			end
			cmp_phase_pkg::SETTLE1: begin
				next_state = cmp_phase_pkg::SETTLE2;
			end
			cmp_phase_pkg::SETTLE2: begin
				// Change flag now reflects the new tracker value
				next_state = cmp_phase_pkg::IDLE;
			end
			default: begin
				next_state = cmp_phase_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK40 or posedge cmp_phs_rst) begin
		if (cmp_phs_rst)
			state <= cmp_phase_pkg::IDLE;
		else
			state <= next_state;
	end

	assign cmp_phs_stat = '{
		psen:  (state == cmp_phase_pkg::SHIFT),
		busy:  (state != cmp_phase_pkg::IDLE),
		state: state
	};

endmodule

`default_nettype wire

// ==== logic/clock_sources.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_sources (
	input  wire                              CLK40,
	input  wire                              RST,
	input  wire                              resync,
	input  wire                              samp_clk_phs_chng,
	input  wire samp_clk_pkg::samp_phase_t   samp_clk_phase,
	input  wire cmp_phase_pkg::cmp_req_t     cmp_clk_phase,
	input  wire                              cmp_phs_jtag_rst,
	input  wire                              mmcm_ps_done,
	input  wire                              mmcm_locked,
	output wire samp_clk_pkg::samp_ctrl_t    samp_ctrl,
	output wire                              dsr_resync,
	output wire cmp_phase_pkg::cmp_phase_t   cmp_phase,
	output wire                              cmp_phs_change,
	output wire cmp_phase_pkg::cmp_phs_stat_t cmp_phs_stat,
	output wire                              cmp_phs_rst,
	output wire                              cmp_phs_inc
);

	// Comparator MMCM and its tracker restart together
	assign cmp_phs_rst = RST | cmp_phs_jtag_rst;

	//--------------------------------------------------------------------------
	// Sampling clock
	//--------------------------------------------------------------------------
	resync_ctrl resync_ctrl_i (
		.CLK40             (CLK40),
		.RST               (RST),
		.resync            (resync),
		.samp_clk_phs_chng (samp_clk_phs_chng),
		.samp_clk_phase    (samp_clk_phase),
		.samp_ctrl         (samp_ctrl)
	);

	dsr_holdoff dsr_holdoff_i (
		.CLK40      (CLK40),
		.RST        (RST),
		.cap_phase  (samp_ctrl.cap_phase),
		.dsr_resync (dsr_resync)
	);

	//--------------------------------------------------------------------------
	// Comparator clock
	//--------------------------------------------------------------------------
	cmp_phase_track cmp_phase_track_i (
		.CLK40          (CLK40),
		.cmp_phs_rst    (cmp_phs_rst),
		.cmp_clk_phase  (cmp_clk_phase),
		.psen           (cmp_phs_stat.psen),
		.cmp_phase      (cmp_phase),
		.cmp_phs_inc    (cmp_phs_inc),
		.cmp_phs_change (cmp_phs_change)
	);

	dyn_phase_shift_fsm dyn_phase_shift_fsm_i (
		.CLK40          (CLK40),
		.cmp_phs_rst    (cmp_phs_rst),
		.mmcm_locked    (mmcm_locked),
		.cmp_phs_change (cmp_phs_change),
		.mmcm_ps_done   (mmcm_ps_done),
		.cmp_phs_stat   (cmp_phs_stat)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clock_sources.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clk_src_defs.svh"

module tb_clock_sources;

	localparam int N_REQ = 3;
	localparam int STEP_CYCLES = 14;    // SHIFT, WAIT_DONE up to 9, two settle, IDLE
	localparam int TIMEOUT_CYCLES = 500 + 2 * 4100
		+ (N_REQ + 1) * (`CMP_STEPS_PER_CYCLE * STEP_CYCLES + 20);

	logic CLK40;
	logic RST;
	logic resync;
	logic samp_clk_phs_chng;
	samp_clk_pkg::samp_phase_t samp_clk_phase;
	cmp_phase_pkg::cmp_req_t cmp_clk_phase;
	logic cmp_phs_jtag_rst;
	logic mmcm_ps_done = 1'b0;
	logic mmcm_locked;
	wire samp_clk_pkg::samp_ctrl_t samp_ctrl;
	wire dsr_resync;
	wire cmp_phase_pkg::cmp_phase_t cmp_phase;
	wire cmp_phs_change;
	wire cmp_phase_pkg::cmp_phs_stat_t cmp_phs_stat;
	wire cmp_phs_rst;
	wire cmp_phs_inc;

	logic [31:0] main_seed = 32'd84;
	logic [31:0] mmcm_seed = 32'd84;
	int cycle_cnt = 0;
	int psen_cnt = 0;     // Running count of PSEN pulses
	int done_dly = 0;
	string cur_test = "startup";
	int test_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// Sampling path model
	logic [1:0] m_rst_dly;
	logic m_resync_d1;
	logic m_lead_d1;
	logic m_cap;
	logic m_par;          // 20 MHz half cycle parity
	logic m_sel;
	int m_rst_cnt;        // Cycles left in the MMCM reset stretch
	logic m_lead;
	logic m_trl;
	samp_clk_pkg::samp_ctrl_t exp_ctrl;

	clock_sources uut (.*);

	initial begin
		CLK40 = 1'b0;
		forever #50 CLK40 = ~CLK40;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int draw(input int span);
		main_seed = lcg_next(main_seed);
		return int'(main_seed[30:16]) % span;
	endfunction

	// Nearest fine step to idx/31 of a 25 ns cycle
	function automatic cmp_phase_pkg::cmp_phase_t table_entry(input int idx);
		return cmp_phase_pkg::cmp_phase_t'((idx * 2 * `CMP_STEPS_PER_CYCLE
			+ (`CMP_TABLE_DEPTH - 1)) / (2 * (`CMP_TABLE_DEPTH - 1)));
	endfunction

	//--------------------------------------------------------------------------
	// Reference model of the resync triggers and the phase select
	//--------------------------------------------------------------------------
	assign m_lead = resync & ~m_resync_d1;
	assign m_trl = ~RST & m_rst_dly[1];     // First two cycles after reset
	assign exp_ctrl = '{
		lead_edg_resync: m_lead,
		cap_phase:       m_cap,
		rst_samp_mmcm:   (m_rst_cnt != 0),
		samp_in_sel:     samp_clk_phase[`SAMP_PHASE_W-1] ^ m_sel
	};

	always @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			m_rst_dly <= 2'b11;
			m_resync_d1 <= 1'b0;
			m_lead_d1 <= 1'b0;
			m_cap <= 1'b0;
			m_par <= 1'b0;
			m_sel <= 1'b0;
			m_rst_cnt <= `MMCM_RST_PIPE_LEN;
		end else begin
			m_rst_dly <= {m_rst_dly[0], 1'b0};
			m_resync_d1 <= resync;
			m_lead_d1 <= m_lead;
			m_cap <= m_lead | m_lead_d1 | m_trl | samp_clk_phs_chng;
			if (m_lead | m_trl | m_cap | samp_clk_phs_chng)
				m_rst_cnt <= `MMCM_RST_PIPE_LEN;
			else if (m_rst_cnt != 0)
				m_rst_cnt <= m_rst_cnt - 1;
			if (m_cap)
				m_sel <= m_par;
			m_par <= m_lead ? 1'b0 : ~m_par;
		end
	end

	// MMCM answers each PSEN with a done pulse 1 to 8 cycles later
	always @(posedge CLK40) begin
		mmcm_ps_done <= 1'b0;
		if (cmp_phs_stat.psen) begin
			psen_cnt <= psen_cnt + 1;
			mmcm_seed = lcg_next(mmcm_seed);
			done_dly <= 1 + int'(mmcm_seed[18:16]);
		end else if (done_dly == 1) begin
			mmcm_ps_done <= 1'b1;
			done_dly <= 0;
		end else if (done_dly > 1)
			done_dly <= done_dly - 1;
	end

	always @(posedge CLK40) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run stopped at the limit of %0d cycles during %s", TIMEOUT_CYCLES, cur_test);
			$display("test failed");
			$finish;
		end
	end

	//--------------------------------------------------------------------------
	// Result checks
	//--------------------------------------------------------------------------
	task automatic note_error(input string msg);
		test_errs++;
		$display("%s", msg);
	endtask

	task automatic bit_check(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			note_error($sformatf("FAIL %s %s: expected %0b, actual %0b",
				cur_test, what, expected, actual));
	endtask

	task automatic ctrl_check(input samp_clk_pkg::samp_ctrl_t expected,
		input samp_clk_pkg::samp_ctrl_t actual);
		if (actual !== expected)
			note_error($sformatf("FAIL %s samp_ctrl: expected %b, actual %b",
				cur_test, expected, actual));
	endtask

	task automatic phase_check(input string what, input cmp_phase_pkg::cmp_phase_t expected,
		input cmp_phase_pkg::cmp_phase_t actual);
		if (actual !== expected)
			note_error($sformatf("FAIL %s %s: expected %0d, actual %0d",
				cur_test, what, expected, actual));
	endtask

	task automatic state_check(input cmp_phase_pkg::dps_state_t expected,
		input cmp_phase_pkg::dps_state_t actual);
		if (actual !== expected)
			note_error($sformatf("FAIL %s state: expected %s, actual %s",
				cur_test, expected.name(), actual.name()));
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("%s: %0d error(s)", cur_test, test_errs);
	endtask

	// Sample at the falling edge, clear of the drive edge
	task automatic run_checked(input int n);
		repeat (n) begin
			@(negedge CLK40);
			ctrl_check(exp_ctrl, samp_ctrl);
		end
	endtask

	// Stepping is over once busy stays low longer than the gap between steps
	task automatic wait_steps(input logic up);
		int idle_run;
		idle_run = 0;
		while (idle_run < 8) begin
			@(negedge CLK40);
			if (cmp_phs_stat.psen)
				bit_check("cmp_phs_inc", up, cmp_phs_inc);    // Every step heads for the target
			idle_run = cmp_phs_stat.busy ? 0 : idle_run + 1;
		end
	endtask

	//--------------------------------------------------------------------------
	// Test sequence
	//--------------------------------------------------------------------------
	initial begin
		int n;
		int lat;
		int base;
		cmp_phase_pkg::cmp_req_t req;
		cmp_phase_pkg::cmp_phase_t old_ph;
		cmp_phase_pkg::cmp_phase_t new_ph;

		RST = 1'b1;
		resync = 1'b0;
		samp_clk_phs_chng = 1'b0;
		samp_clk_phase = '0;
		cmp_clk_phase = '0;
		cmp_phs_jtag_rst = 1'b0;
		mmcm_locked = 1'b0;
		repeat (3) @(posedge CLK40);
		RST <= 1'b0;
		mmcm_locked <= 1'b1;

		start_test("after_reset");
		run_checked(1);
		bit_check("psen", 1'b0, cmp_phs_stat.psen);
		bit_check("busy", 1'b0, cmp_phs_stat.busy);
		bit_check("dsr_resync", 1'b0, dsr_resync);
		bit_check("cmp_phs_change", 1'b0, cmp_phs_change);
		bit_check("rst_samp_mmcm", 1'b1, samp_ctrl.rst_samp_mmcm);
		run_checked(1);
		bit_check("cap_phase", 1'b1, samp_ctrl.cap_phase);
		n = 2;
		while (samp_ctrl.rst_samp_mmcm && n < 16) begin
			run_checked(1);
			n++;
		end
		if (n > 12)
			note_error($sformatf("rst_samp_mmcm stayed high %0d cycles after reset", n));
		finish_test();

		start_test("resync_edge");
		@(posedge CLK40);
		resync <= 1'b1;
		run_checked(1);
		bit_check("lead_edg_resync", 1'b1, samp_ctrl.lead_edg_resync);
		run_checked(1);
		bit_check("lead_edg_resync", 1'b0, samp_ctrl.lead_edg_resync);
		bit_check("cap_phase", 1'b1, samp_ctrl.cap_phase);
		run_checked(2);
		bit_check("cap_phase", 1'b0, samp_ctrl.cap_phase);
		n = 0;
		while (samp_ctrl.rst_samp_mmcm && n < 20) begin
			run_checked(1);
			n++;
		end
		if (n < `MMCM_RST_PIPE_LEN)
			note_error($sformatf("rst_samp_mmcm dropped %0d cycles after cap_phase", n));
		@(posedge CLK40);
		resync <= 1'b0;
		run_checked(2);
		finish_test();

		start_test("samp_select");
		repeat (8) begin
			@(posedge CLK40);
			samp_clk_phase <= samp_clk_pkg::samp_phase_t'(draw(8));
			run_checked(draw(8) + 1);
			@(posedge CLK40);
			if (draw(2) == 0)
				resync <= 1'b1;
			else
				samp_clk_phs_chng <= 1'b1;
			run_checked(1);
			@(posedge CLK40);
			samp_clk_phs_chng <= 1'b0;
			run_checked(draw(6) + 1);
			@(posedge CLK40);
			resync <= 1'b0;
			run_checked(12);
			bit_check("samp_in_sel", samp_clk_phase[`SAMP_PHASE_W-1] ^ m_sel,
				samp_ctrl.samp_in_sel);
		end
		finish_test();

		start_test("holdoff");
		while (dsr_resync)
			run_checked(1);
		@(posedge CLK40);
		samp_clk_phs_chng <= 1'b1;
		run_checked(1);
		@(posedge CLK40);
		samp_clk_phs_chng <= 1'b0;
		run_checked(1);
		bit_check("dsr_resync", 1'b0, dsr_resync);
		run_checked(1);
		bit_check("dsr_resync", 1'b1, dsr_resync);
		lat = 0;
		while (dsr_resync) begin
			run_checked(1);
			lat++;
		end
		if (lat < 3960 || lat > 4041)
			note_error($sformatf("dsr_resync held %0d cycles, not 3960 to 4041", lat));
		finish_test();

		start_test("cmp_stepping");
		old_ph = '0;
		repeat (N_REQ) begin
			req = cmp_phase_pkg::cmp_req_t'(draw(`CMP_TABLE_DEPTH));
			new_ph = table_entry(int'(req));
			base = psen_cnt;
			@(posedge CLK40);
			cmp_clk_phase <= req;
			wait_steps(new_ph > old_ph);
			phase_check("cmp_phase", new_ph, cmp_phase);
			phase_check("psen pulses", (new_ph > old_ph) ? new_ph - old_ph : old_ph - new_ph,
				cmp_phase_pkg::cmp_phase_t'(psen_cnt - base));
			bit_check("busy", 1'b0, cmp_phs_stat.busy);
			bit_check("cmp_phs_change", 1'b0, cmp_phs_change);
			state_check(cmp_phase_pkg::IDLE, cmp_phs_stat.state);
			old_ph = new_ph;
		end
		finish_test();

		// Tracker restarts at 0 and must climb back to the current entry
		start_test("jtag_reset");
		base = psen_cnt;
		@(posedge CLK40);
		cmp_phs_jtag_rst <= 1'b1;
		@(negedge CLK40);
		bit_check("cmp_phs_rst", 1'b1, cmp_phs_rst);
		@(posedge CLK40);
		cmp_phs_jtag_rst <= 1'b0;
		wait_steps(1'b1);
		phase_check("psen pulses", old_ph, cmp_phase_pkg::cmp_phase_t'(psen_cnt - base));
		bit_check("busy", 1'b0, cmp_phs_stat.busy);
		bit_check("cmp_phs_change", 1'b0, cmp_phs_change);
		state_check(cmp_phase_pkg::IDLE, cmp_phs_stat.state);
		finish_test();

		$display("%0d tests run, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== comp_phase.hex ====
000
02B
057
082
0AD
0D9
104
12F
15B
186
1B2
1DD
208
234
25F
28A
2B6
2E1
30C
338
363
38E
3BA
3E5
411
43C
467
493
4BE
4E9
515
540

// ==== project.f ====
+incdir+logic
logic/samp_clk_pkg.sv
logic/cmp_phase_pkg.sv
logic/resync_ctrl.sv
logic/dsr_holdoff.sv
logic/cmp_phase_track.sv
logic/dyn_phase_shift_fsm.sv
logic/clock_sources.sv
sim/tb_clock_sources.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the clock source testbench, then scan its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns -f project.f \
	--top-module tb_clock_sources -o tb_clock_sources \
	&& ./obj_dir/tb_clock_sources | tee sim.log \
	|| exit 1
! grep -qx "test failed" sim.log && grep -qx "test passed" sim.log
